/* filelist.f */
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_top.sv
uart_properties.sv
tb_uart_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the UART testbench with Verilator and runs it, the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module tb_uart_top -o tb_uart_top \
  && ./obj_dir/tb_uart_top \
  || { echo "simulation did not complete successfully"; exit 1; }

/* tb_uart_top.sv */
/*
  Testbench for uart_top with loopback and direct-drive frames from a fixed LFSR seed.
  The run stops at the first mismatch, and a cycle limit bounds the whole run
*/
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

  import uart_pkg::*;

  logic                 clk;
  logic                 rst_n;
  logic                 go;
  logic                 tx_start;
  logic [data_bits-1:0] tx_data;
  logic                 loop_sel;
  logic                 rx_drv;
  logic                 rx_pin;
  logic [data_bits-1:0] rx_data;
  logic                 rx_ready;
  logic                 tx;
  logic                 tx_busy;

  string                test_name;
  logic [31:0]          lfsr_state;
  int                   cycle_cnt;

  // bytes handed to the transmitter and bytes the receiver should deliver, in order
  logic [data_bits-1:0] tx_q[$];
  logic [data_bits-1:0] rx_q[$];

  // state of the comparison process
  int                   tx_edge;
  logic [9:0]           exp_frame;
  logic [data_bits-1:0] exp_byte;
  logic                 busy_prev;
  logic                 ready_prev;

  // the receiver listens either to the transmitter or to the serial driver task
  assign rx_pin = loop_sel ? tx : rx_drv;

  uart_top uart_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx_pin),
    .go       (go),
    .rx_data  (rx_data),
    .rx_ready (rx_ready),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  always #20 clk = ~clk;

  // expected line levels of one frame where index 0 goes out first
  function automatic logic [9:0] frame_of(input logic [data_bits-1:0] b);
    return {1'b1, b, 1'b0};
  endfunction

  // 32-bit Fibonacci LFSR with taps at bits 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "run stopped after a failed check");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    report_failure($sformatf("FAILED %s %s expected %0h actual %0h",
                             test_name, what, exp, act));
  endtask

  // drives a one-cycle strobe that the transmitter takes on the second edge
  task automatic send_byte(input logic [data_bits-1:0] b);
    @(posedge clk);
    tx_start <= 1'b1;
    tx_data  <= b;
    @(posedge clk);
    tx_start <= 1'b0;
  endtask

  // drives a whole frame on rx_drv at bit_time cycles per bit
  task automatic send_serial(input logic [data_bits-1:0] b);
    logic [9:0] f;
    f = frame_of(b);
    repeat (10) begin
      @(posedge clk);
      rx_drv <= f[0];
      f = f >> 1;
      repeat (bit_time - 1) begin
        @(posedge clk);
      end
    end
  endtask

  task automatic wait_rx_ready();
    while (!rx_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_tx_idle();
    @(posedge clk);
    while (tx_busy) begin
      @(posedge clk);
    end
  endtask

  // the receiver sees go low one edge later, and both outputs read zero after that edge
  task automatic release_go();
    @(posedge clk);
    go <= 1'b0;
    @(posedge clk);
    repeat (3) begin
      @(posedge clk);
      assert (!rx_ready) else report_mismatch("rx_ready after go fell", 0, 32'(rx_ready));
      assert (rx_data == '0) else report_mismatch("rx_data after go fell", 0, 32'(rx_data));
    end
    go <= 1'b1;
  endtask

  // 40 frames at twice their nominal length is well above the longest run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > 40 * 10 * bit_time * 2) begin
      report_failure("timeout: the tests did not finish within the cycle limit");
    end
  end

  // the comparison process reads outputs before this edge's flop updates land
  always @(posedge clk) begin
    if (rst_n) begin
      if (tx_edge == 0) begin
        if (tx_busy && !busy_prev) begin
          assert (tx_q.size() > 0)
            else report_failure("tx_busy rose although no byte was handed to the transmitter");
          exp_frame = frame_of(tx_q.pop_front());
          tx_edge   = 1;
        end
      end else begin
        tx_edge = tx_edge + 1;
      end
      if (tx_edge != 0) begin
        // tx_edge counts edges since the taking edge, so bit centres sit at half_bit_time
        if (tx_edge % bit_time == half_bit_time) begin
          assert (tx == exp_frame[0]) else report_mismatch("tx bit", 32'(exp_frame[0]), 32'(tx));
          exp_frame = exp_frame >> 1;
        end
        if (tx_edge == 10 * bit_time) begin
          assert (tx_busy) else report_mismatch("busy in last cycle", 1, 32'(tx_busy));
        end
        if (tx_edge == 10 * bit_time + 1) begin
          assert (!tx_busy) else report_mismatch("busy after ten bit times", 0, 32'(tx_busy));
          tx_edge = 0;
        end
      end
      if (rx_ready && !ready_prev) begin
        assert (rx_q.size() > 0)
          else report_failure("rx_ready rose although no frame was expected");
        exp_byte = rx_q.pop_front();
        assert (rx_data == exp_byte)
          else report_mismatch("rx_data", 32'(exp_byte), 32'(rx_data));
        if (loop_sel) begin
          // one edge to the first low sample, the receive latency, one edge to see dr
          assert (tx_edge == 1 + 2 + half_bit_time + 9 * bit_time + 1)
            else report_mismatch("rx latency", 32'(4 + half_bit_time + 9 * bit_time),
                                 32'(tx_edge));
        end
      end
    end
    busy_prev  = tx_busy;
    ready_prev = rx_ready;
  end

  initial begin : stimulus
    logic [31:0]          r;
    logic [data_bits-1:0] b;
    clk        = 1'b0;
    rst_n      = 1'b0;
    go         = 1'b0;
    tx_start   = 1'b0;
    tx_data    = '0;
    loop_sel   = 1'b0;
    rx_drv     = 1'b1;
    cycle_cnt  = 0;
    tx_edge    = 0;
    busy_prev  = 1'b0;
    ready_prev = 1'b0;
    lfsr_state = 32'h174d6515;

    test_name = "reset";
    repeat (4) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;
    @(posedge clk);
    assert (tx) else report_mismatch("tx", 1, 32'(tx));
    assert (!tx_busy) else report_mismatch("tx_busy", 0, 32'(tx_busy));
    assert (!rx_ready) else report_mismatch("rx_ready", 0, 32'(rx_ready));
    assert (rx_data == '0) else report_mismatch("rx_data", 0, 32'(rx_data));

    test_name = "loopback";
    loop_sel <= 1'b1;
    go       <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      take_bits(data_bits, r);
      b = r[data_bits-1:0];
      tx_q.push_back(b);
      rx_q.push_back(b);
      send_byte(b);
      wait_rx_ready();
      release_go();
      wait_tx_idle();
    end

    test_name = "hand-off";
    take_bits(data_bits, r);
    b = r[data_bits-1:0];
    tx_q.push_back(b);
    rx_q.push_back(b);
    send_byte(b);
    wait_rx_ready();
    repeat (3 * bit_time) begin
      @(posedge clk);
      assert (rx_ready) else report_mismatch("rx_ready held", 1, 32'(rx_ready));
      assert (rx_data == b) else report_mismatch("rx_data held", 32'(b), 32'(rx_data));
    end
    release_go();
    wait_tx_idle();

    test_name = "disarmed receiver";
    loop_sel <= 1'b0;
    go       <= 1'b0;
    take_bits(data_bits, r);
    send_serial(r[data_bits-1:0]);
    repeat (2 * bit_time) begin
      @(posedge clk);
      assert (!rx_ready) else report_mismatch("rx_ready", 0, 32'(rx_ready));
      assert (rx_data == '0) else report_mismatch("rx_data", 0, 32'(rx_data));
    end

    test_name = "transmit busy";
    take_bits(data_bits, r);
    b = r[data_bits-1:0];
    tx_q.push_back(b);
    send_byte(b);
    repeat (3 * bit_time) begin
      @(posedge clk);
    end
    assert (tx_busy) else report_mismatch("tx_busy at second strobe", 1, 32'(tx_busy));
    // this strobe lands mid-frame and must be dropped
    take_bits(data_bits, r);
    send_byte(r[data_bits-1:0]);
    wait_tx_idle();
    repeat (2 * bit_time) begin
      @(posedge clk);
      assert (!tx_busy && tx)
        else report_failure("the transmitter started a frame for a strobe taken while busy");
    end

    test_name = "direct receive";
    go <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      take_bits(data_bits, r);
      b = r[data_bits-1:0];
      rx_q.push_back(b);
      send_serial(b);
      wait_rx_ready();
      release_go();
      take_bits(6, r);
      repeat (int'(r[5:0]) + 1) begin
        @(posedge clk);
      end
    end

    test_name = "end of run";
    if (tx_q.size() == 0 && rx_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("bytes were queued but their frames never showed on the DUT outputs");
    end
  end

endmodule

`default_nettype wire

/* uart_properties.sv */
/*
  Protocol assertions bound into uart_top. They watch both blocks through the top-level pins.
  go must stay high for a whole frame once the receiver is armed
*/
`timescale 1ns/1ps
`default_nettype none

module uart_properties (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           go,
  input logic                           dr,
  input logic [uart_pkg::data_bits-1:0] data,
  input logic                           busy
);

  import uart_pkg::*;

  // length of the current busy interval in cycles
  int busy_len;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_len <= 0;
    end else if (busy) begin
      busy_len <= busy_len + 1;
    end else begin
      busy_len <= 0;
    end
  end

  // a disarmed receiver never reports a byte
  assert property (@(posedge clk) disable iff (!rst_n) $rose(dr) |-> go)
    else $error("dr rose while go was low");

  // the byte and dr hold for as long as the host keeps go high
  assert property (@(posedge clk) disable iff (!rst_n) dr && go |=> dr && $stable(data))
    else $error("dr or data changed before go fell");

  // the hand-off clears both outputs one cycle after go falls
  assert property (@(posedge clk) disable iff (!rst_n) dr && !go |=> !dr && data == '0)
    else $error("dr or data not cleared after go fell");

  // a frame keeps busy high for exactly ten bit times
  assert property (@(posedge clk) disable iff (!rst_n) busy |-> busy_len < 10 * bit_time)
    else $error("busy stayed high longer than ten bit times");

  assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> busy_len == 10 * bit_time)
    else $error("busy fell before ten bit times had passed");

endmodule

bind uart_top uart_properties uart_properties_inst (
  .clk   (clk),
  .rst_n (rst_n),
  .go    (go),
  .dr    (rx_ready),
  .data  (rx_data),
  .busy  (tx_busy)
);

`default_nettype wire

/* uart_top.sv */
/*
  UART subsystem top with one receiver and one transmitter on separate pins.
  Pure wiring adds no cycles, and loopback, if wanted, is made outside this block
*/
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // receive side, rx is the serial input pin
  input  logic                           rx,
  input  logic                           go,
  output logic [uart_pkg::data_bits-1:0] rx_data,
  output logic                           rx_ready,
  // transmit side, tx is the serial output pin
  input  logic                           tx_start,
  input  logic [uart_pkg::data_bits-1:0] tx_data,
  output logic                           tx,
  output logic                           tx_busy
);

  // the receiver owns its own synchronizer, so rx goes straight in
  uart_rx uart_rx_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .go    (go),
    .data  (rx_data),
    .dr    (rx_ready)
  );

  // tx_start is a single-cycle strobe and tx_busy reports the frame in progress
  uart_tx uart_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx       (tx),
    .busy     (tx_busy)
  );

endmodule

`default_nettype wire

/* uart_tx.sv */
/*
  8N1 transmitter. A tx_start pulse is taken only while busy is low, and a pulse during a
  frame is dropped, not queued. busy stays high for exactly ten bit times per frame
*/
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           tx_start,
  input  logic [uart_pkg::data_bits-1:0] tx_data,
  output logic                           tx,
  output logic                           busy
);

  import uart_pkg::*;

  tx_state_t             state;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [bit_idx_w-1:0]  bit_idx;

  // holds the bits not yet sent, and bit 0 is always the next one out
  logic [data_bits-1:0]  shift_q;

  // loads on the taking edge and drops one bit as each start or data bit ends
  always_ff @(posedge clk) begin
    if (state == tx_idle && tx_start) begin
      shift_q <= tx_data;
    end else if (state != tx_idle && state != tx_stop_bit && bit_cnt == '0) begin
      shift_q <= shift_q >> 1;
    end
  end

  // tx is a flop, so the line changes only on clock edges and never glitches
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      busy    <= 1'b0;
    end else begin
      case (state)

        tx_idle: begin
          // the taking edge starts the start bit and raises busy at once
          if (tx_start) begin
            tx      <= 1'b0;
            busy    <= 1'b1;
            bit_idx <= '0;
            bit_cnt <= bit_cnt_w'(bit_time - 1);
            state   <= tx_start_bit;
          end
        end

        tx_start_bit: begin
          if (bit_cnt == '0) begin
            // first data bit goes out as the start bit ends
            tx      <= shift_q[0];
            bit_cnt <= bit_cnt_w'(bit_time - 1);
            state   <= tx_data_bits;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        tx_data_bits: begin
          if (bit_cnt == '0) begin
            bit_cnt <= bit_cnt_w'(bit_time - 1);
            if (bit_idx == bit_idx_w'(data_bits - 1)) begin
              // last data bit is done and the line goes high for the stop bit
              tx      <= 1'b1;
              bit_idx <= '0;
              state   <= tx_stop_bit;
            end else begin
              tx      <= shift_q[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        tx_stop_bit: begin
          // busy falls on the same edge that returns the FSM to idle
          if (bit_cnt == '0) begin
            busy  <= 1'b0;
            state <= tx_idle;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        default: begin
          tx    <= 1'b1;
          busy  <= 1'b0;
          state <= tx_idle;
        end

      endcase
    end
  end

endmodule

`default_nettype wire

/* uart_rx.sv */
/*
  8N1 receiver with a level handshake. No start, stop or parity checks and no error recovery.
  Frames that arrive while go is low, or while dr waits for go to fall, are lost
*/
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           rx,
  input  logic                           go,
  output logic [uart_pkg::data_bits-1:0] data,
  output logic                           dr
);

  import uart_pkg::*;

  // the line is asynchronous to clk, so it passes two flops before the FSM sees it
  logic rx_meta;
  logic rx_s;

  rx_state_t             state;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [bit_idx_w-1:0]  bit_idx;

  // both flops reset high because the idle line is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
    end
  end

  // the down-counter reloads with one tick less than the interval
  // because the cycle that switches state already counts as the first tick
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= rx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      data    <= '0;
      dr      <= 1'b0;
    end else begin
      case (state)

        rx_idle: begin
          // only an armed receiver takes a falling line as a start bit
          if (go && !rx_s) begin
            bit_idx <= '0;
            bit_cnt <= bit_cnt_w'(half_bit_time - 1);
            state   <= rx_start_bit;
          end
        end

        rx_start_bit: begin
          // at the start-bit centre, so every later sample lands mid-bit
          if (bit_cnt == '0) begin
            bit_cnt <= bit_cnt_w'(bit_time - 1);
            state   <= rx_data_bits;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        rx_data_bits: begin
          if (bit_cnt == '0) begin
            // bits arrive LSB first, so the index is the bit position
            data[bit_idx] <= rx_s;
            bit_cnt       <= bit_cnt_w'(bit_time - 1);
            bit_idx       <= bit_idx + 1'b1;
            // bit_idx still holds the old value here, so the last bit shows as data_bits-1
            if (bit_idx == bit_idx_w'(data_bits - 1)) begin
              bit_idx <= '0;
              state   <= rx_stop_bit;
            end
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        rx_stop_bit: begin
          // the stop bit is timed but its level is not checked
          if (bit_cnt == '0) begin
            dr    <= 1'b1;
            state <= rx_wait_go_low;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end

        rx_wait_go_low: begin
          // data and dr hold until the host drops go, then both clear together
          if (!go) begin
            data  <= '0;
            dr    <= 1'b0;
            state <= rx_idle;
          end
        end

        default: begin
          // a corrupted one-hot word falls back to idle with the outputs cleared
          data  <= '0;
          dr    <= 1'b0;
          state <= rx_idle;
        end

      endcase
    end
  end

endmodule

`default_nettype wire

/* uart_pkg.sv */
/*
  Shared UART constants for a fixed 8N1 frame. Clock and baud are fixed at build time, and
  clk_freq must be an exact multiple of baud_rate with at least four cycles per bit
*/
`default_nettype none

package uart_pkg;

  // system clock in Hz, kept low so that a frame is short in simulation
  localparam int clk_freq = 1_600_000;

  // serial line rate in bits per second
  localparam int baud_rate = 100_000;

  // clock cycles per bit on the line (16 at the rates above)
  localparam int bit_time = clk_freq / baud_rate;

  // cycles from start-bit detection to the centre of the start bit
  localparam int half_bit_time = bit_time / 2;

  // payload bits per frame, no parity and a single stop bit follow them
  localparam int data_bits = 8;

  // width of the per-bit down-counter, which counts from bit_time-1 to 0
  localparam int bit_cnt_w = $clog2(bit_time);

  // width of the index that walks the data bits of a frame
  localparam int bit_idx_w = $clog2(data_bits);

  // receiver states, one-hot so that each state is a single flop
  typedef enum logic [4:0] {
    rx_idle        = 5'b00001,
    rx_start_bit   = 5'b00010,
    rx_data_bits   = 5'b00100,
    rx_stop_bit    = 5'b01000,
    rx_wait_go_low = 5'b10000
  } rx_state_t;

  // transmitter states, binary coded
  typedef enum logic [1:0] {
    tx_idle      = 2'd0,
    tx_start_bit = 2'd1,
    tx_data_bits = 2'd2,
    tx_stop_bit  = 2'd3
  } tx_state_t;

endpackage

`default_nettype wire
